// File: tb.f
rtl/cache_pkg.sv
rtl/access_timer.sv
rtl/main_memory.sv
rtl/cache_store.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
tb/cache_tb.sv

// File: Makefile
# Verilator build and run for the cache testbench

LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
		--top-module cache_tb -Mdir obj_dir -f tb.f

# Pass or fail comes from the log, not the exit code
run: build
	./obj_dir/Vcache_tb > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation passed" $(LOG)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		--top-module cache_top \
		rtl/cache_pkg.sv rtl/access_timer.sv rtl/main_memory.sv \
		rtl/cache_store.sv rtl/cache_ctrl.sv rtl/cache_top.sv
	verilator --lint-only --timing --timescale 1ns/1ps \
		--top-module cache_tb -f tb.f

clean:
	rm -rf obj_dir $(LOG)

// File: tb/cache_tb.sv
module cache_tb
    import cache_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // 15 directed requests and the rest random
    localparam int NUM_RANDOM     = 385;
    localparam int MAX_REQUESTS   = 400;
    localparam int TIMEOUT_CYCLES = MAX_REQUESTS * 40;

    logic                 clk;
    logic                 rst;
    logic                 read_m;
    logic                 write_m;
    logic [WORD_SIZE-1:0] addr;
    logic [WORD_SIZE-1:0] data_in;
    logic [WORD_SIZE-1:0] data_out;
    logic                 valid;
    logic                 hit;

    // Reference copy of memory and cache state
    logic [WORD_SIZE-1:0] ref_mem   [MEM_WORDS];
    logic [TAG_W-1:0]     ref_tag   [NUM_SETS][NUM_WAYS];
    logic                 ref_valid [NUM_SETS][NUM_WAYS];
    logic [WORD_SIZE-1:0] ref_line  [NUM_SETS][NUM_WAYS][LINE_WORDS];
    logic                 ref_mru   [NUM_SETS];

    // Entry layout is {is_write, hit, data}
    logic [17:0] expected_q [$];
    logic [17:0] expected_entry;

    logic [31:0] lfsr = 32'h54ad;
    int          issued = 0;
    int          responses = 0;
    int          cycle_count = 0;

    cache_top cache_top_inst (
        .clk      (clk),
        .rst      (rst),
        .read_m   (read_m),
        .write_m  (write_m),
        .addr     (addr),
        .data_in  (data_in),
        .data_out (data_out),
        .valid    (valid),
        .hit      (hit)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = next_lfsr(lfsr);
            bits = {bits[14:0], lfsr[0]};
        end
        return bits;
    endfunction

    // Small tag pool so that sets fill up and evict often
    function automatic logic [TAG_W-1:0] pool_tag(input logic [1:0] sel);
        case (sel)
            2'd0: return 12'h000;
            2'd1: return 12'h001;
            2'd2: return 12'h0a5;
            default: return 12'h3c2;
        endcase
    endfunction

    function automatic logic [WORD_SIZE-1:0] make_addr(input logic [TAG_W-1:0] tag,
                                                       input logic idx,
                                                       input logic [1:0] off);
        return {tag, idx, off, 1'b0};
    endfunction

    task automatic init_model();
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = mem_init_word(i);
        end
        for (int s = 0; s < NUM_SETS; s++) begin
            ref_mru[s] = 1'b0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
            end
        end
    endtask

    // Returns {hit, data} and updates the reference state
    function automatic logic [16:0] model_access(input logic is_write,
                                                 input logic [WORD_SIZE-1:0] a,
                                                 input logic [WORD_SIZE-1:0] wd);
        logic                 idx;
        logic [TAG_W-1:0]     tag;
        logic [1:0]           off;
        logic [MEM_AW-1:0]    midx;
        logic                 found;
        logic                 way;
        logic [WORD_SIZE-1:0] rdata;
        idx   = a[IDX_BIT];
        tag   = a[TAG_MSB:TAG_LSB];
        off   = a[OFF_MSB:OFF_LSB];
        midx  = a[MEM_AW:1];
        found = 1'b0;
        way   = 1'b0;
        rdata = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ref_valid[idx][w] && (ref_tag[idx][w] == tag)) begin
                found = 1'b1;
                way   = w[0];
            end
        end
        if (is_write) begin
            // Memory always takes the write and the cached copy only on a hit
            ref_mem[midx] = wd;
            if (found) begin
                ref_line[idx][way][off] = wd;
                ref_mru[idx]            = way;
            end
        end else if (found) begin
            rdata        = ref_line[idx][way][off];
            ref_mru[idx] = way;
        end else begin
            if (!ref_valid[idx][0]) begin
                way = 1'b0;
            end else if (!ref_valid[idx][1]) begin
                way = 1'b1;
            end else begin
                way = !ref_mru[idx];
            end
            for (int b = 0; b < LINE_WORDS; b++) begin
                ref_line[idx][way][b] = ref_mem[{midx[MEM_AW-1:2], 2'(b)}];
            end
            ref_tag[idx][way]   = tag;
            ref_valid[idx][way] = 1'b1;
            ref_mru[idx]        = way;
            rdata               = ref_mem[midx];
        end
        return {found, rdata};
    endfunction

    // exp_hit of -1 leaves the hit to the compare process alone
    task automatic run_request(input logic is_write, input logic [WORD_SIZE-1:0] a,
                               input logic [WORD_SIZE-1:0] wd, input int exp_hit);
        logic [16:0] expected;
        int          waited;
        expected = model_access(is_write, a, wd);
        expected_q.push_back({is_write, expected});
        issued++;
        read_m  = !is_write;
        write_m = is_write;
        addr    = a;
        data_in = wd;
        waited  = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (valid !== 1'b1);
        if (exp_hit >= 0) begin
            check_value("hit", 32'(hit), 32'(exp_hit));
        end
        // Read hit answers two edges after the first sample
        if (!is_write && expected[16]) begin
            check_value("valid latency", 32'(waited), 32'd2);
        end
        @(negedge clk);
        read_m  = 1'b0;
        write_m = 1'b0;
    endtask

    always @(negedge clk) begin
        if (valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                $display("valid pulse seen with no request outstanding");
                $display("Simulation failed");
                $fatal(1);
            end else begin
                expected_entry = expected_q.pop_front();
                check_value("hit", 32'(hit), 32'(expected_entry[16]));
                if (!expected_entry[17]) begin
                    check_value("data_out", 32'(data_out), 32'(expected_entry[15:0]));
                end
                responses++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, only %0d of %0d requests answered",
                     cycle_count, responses, issued);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    initial begin
        logic [15:0]          r_op;
        logic [15:0]          r_tag;
        logic [15:0]          r_low;
        logic [15:0]          r_data;
        logic [WORD_SIZE-1:0] a;
        rst     = 1'b1;
        read_m  = 1'b0;
        write_m = 1'b0;
        addr    = '0;
        data_in = '0;
        init_model();
        repeat (3) @(negedge clk);
        rst = 1'b0;

        // Cold reads and then the same lines again
        run_request(1'b0, make_addr(12'h000, 1'b0, 2'd1), 16'h0000, 0);
        run_request(1'b0, make_addr(12'h000, 1'b1, 2'd2), 16'h0000, 0);
        run_request(1'b0, make_addr(12'h000, 1'b0, 2'd3), 16'h0000, 1);
        run_request(1'b0, make_addr(12'h000, 1'b1, 2'd0), 16'h0000, 1);

        // Set 0 fills up and A stays newest so C pushes B out
        run_request(1'b0, make_addr(12'h001, 1'b0, 2'd0), 16'h0000, 0);
        run_request(1'b0, make_addr(12'h000, 1'b0, 2'd2), 16'h0000, 1);
        run_request(1'b0, make_addr(12'h0a5, 1'b0, 2'd1), 16'h0000, 0);
        run_request(1'b0, make_addr(12'h000, 1'b0, 2'd0), 16'h0000, 1);
        run_request(1'b0, make_addr(12'h001, 1'b0, 2'd0), 16'h0000, 0);
        run_request(1'b0, make_addr(12'h000, 1'b0, 2'd1), 16'h0000, 1);

        // Write hit updates the line
        run_request(1'b1, make_addr(12'h000, 1'b0, 2'd1), 16'hbeef, 1);
        run_request(1'b0, make_addr(12'h000, 1'b0, 2'd1), 16'h0000, 1);

        // Write miss goes to memory only
        run_request(1'b1, make_addr(12'h3c2, 1'b1, 2'd3), 16'h1234, 0);
        run_request(1'b0, make_addr(12'h3c2, 1'b1, 2'd3), 16'h0000, 0);
        run_request(1'b0, make_addr(12'h3c2, 1'b1, 2'd3), 16'h0000, 1);

        // Random mix with about one write in four
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r_op   = take_bits(2);
            r_tag  = take_bits(2);
            r_low  = take_bits(4);
            r_data = take_bits(16);
            a      = {pool_tag(r_tag[1:0]), r_low[3:0]};
            run_request(r_op[1:0] == 2'b00, a, r_data, -1);
        end

        repeat (2) @(negedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: rtl/cache_top.sv
module cache_top
    import cache_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 read_m,
    input  logic                 write_m,
    input  logic [WORD_SIZE-1:0] addr,
    input  logic [WORD_SIZE-1:0] data_in,
    output logic [WORD_SIZE-1:0] data_out,
    output logic                 valid,
    output logic                 hit
);

    // Controller and store
    logic                 lookup_en;
    logic                 fill_en;
    logic                 tag_write;
    logic                 write_hit_en;
    logic                 lru_touch;
    logic                 fill_way;
    logic [1:0]           fill_word;
    logic [WORD_SIZE-1:0] fill_data;
    logic                 store_hit;
    logic                 hit_way;
    logic                 victim_way;
    logic [WORD_SIZE-1:0] rd_word;

    // Controller and memory
    logic                 mem_read;
    logic                 mem_write;
    logic [WORD_SIZE-1:0] mem_addr;
    logic [WORD_SIZE-1:0] mem_wdata;
    logic [WORD_SIZE-1:0] mem_rdata;
    logic                 mem_stall;

    cache_ctrl ctrl_inst (
        .clk          (clk),
        .rst          (rst),
        .read_m       (read_m),
        .write_m      (write_m),
        .addr         (addr),
        .data_in      (data_in),
        .hit_in       (store_hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .rd_word      (rd_word),
        .mem_rdata    (mem_rdata),
        .mem_stall    (mem_stall),
        .lookup_en    (lookup_en),
        .fill_en      (fill_en),
        .tag_write    (tag_write),
        .write_hit_en (write_hit_en),
        .lru_touch    (lru_touch),
        .fill_way     (fill_way),
        .fill_word    (fill_word),
        .fill_data    (fill_data),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .data_out     (data_out),
        .valid        (valid),
        .hit          (hit)
    );

    cache_store store_inst (
        .clk          (clk),
        .rst          (rst),
        .addr         (addr),
        .lookup_en    (lookup_en),
        .fill_en      (fill_en),
        .tag_write    (tag_write),
        .write_hit_en (write_hit_en),
        .lru_touch    (lru_touch),
        .fill_way     (fill_way),
        .fill_word    (fill_word),
        .fill_data    (fill_data),
        .data_in      (data_in),
        .hit          (store_hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .rd_word      (rd_word)
    );

    main_memory memory_inst (
        .clk       (clk),
        .rst       (rst),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_stall (mem_stall)
    );

endmodule

// File: rtl/cache_ctrl.sv
module cache_ctrl
    import cache_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 read_m,
    input  logic                 write_m,
    input  logic [WORD_SIZE-1:0] addr,
    input  logic [WORD_SIZE-1:0] data_in,
    input  logic                 hit_in,
    input  logic                 hit_way,
    input  logic                 victim_way,
    input  logic [WORD_SIZE-1:0] rd_word,
    input  logic [WORD_SIZE-1:0] mem_rdata,
    input  logic                 mem_stall,
    output logic                 lookup_en,
    output logic                 fill_en,
    output logic                 tag_write,
    output logic                 write_hit_en,
    output logic                 lru_touch,
    output logic                 fill_way,
    output logic [1:0]           fill_word,
    output logic [WORD_SIZE-1:0] fill_data,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic [WORD_SIZE-1:0] mem_addr,
    output logic [WORD_SIZE-1:0] mem_wdata,
    output logic [WORD_SIZE-1:0] data_out,
    output logic                 valid,
    output logic                 hit
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        FILL_REQ,
        FILL_WAIT,
        WRITE_REQ,
        WRITE_WAIT,
        DONE
    } state_t;

    state_t     state;
    logic [1:0] beat;
    logic       fill_way_q;
    logic       filling;

    assign filling = (state == FILL_REQ) || (state == FILL_WAIT);

    assign lookup_en = (state == IDLE) && (read_m || write_m);
    assign lru_touch = (state == LOOKUP) && hit_in;

    // One refill beat per finished memory read
    assign fill_en      = (state == FILL_WAIT) && !mem_stall;
    assign tag_write    = fill_en && (beat == 2'(LINE_WORDS - 1));
    assign write_hit_en = (state == WRITE_WAIT) && !mem_stall && hit_in;

    // Way select: refill target during a fill, hit way otherwise
    assign fill_way  = filling ? fill_way_q : hit_way;
    assign fill_word = beat;
    assign fill_data = mem_rdata;

    // Strobes held while stalled, released once stall is low
    assign mem_read  = (state == FILL_REQ) || ((state == FILL_WAIT) && mem_stall);
    assign mem_write = (state == WRITE_REQ) || ((state == WRITE_WAIT) && mem_stall);
    assign mem_wdata = data_in;

    always_comb begin
        if (filling) begin
            mem_addr = {addr[TAG_MSB:IDX_BIT], beat, 1'b0};
        end else begin
            mem_addr = {addr[WORD_SIZE-1:1], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            beat  <= '0;
            valid <= 1'b0;
            hit   <= 1'b0;
        end else begin
            valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (read_m || write_m) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (write_m) begin
                        state <= WRITE_REQ;
                    end else if (hit_in) begin
                        hit   <= 1'b1;
                        valid <= 1'b1;
                        state <= DONE;
                    end else begin
                        beat  <= '0;
                        state <= FILL_REQ;
                    end
                end
                FILL_REQ: begin
                    state <= FILL_WAIT;
                end
                FILL_WAIT: begin
                    if (!mem_stall) begin
                        if (tag_write) begin
                            hit   <= 1'b0;
                            valid <= 1'b1;
                            state <= DONE;
                        end else begin
                            beat  <= beat + 1'b1;
                            state <= FILL_REQ;
                        end
                    end
                end
                WRITE_REQ: begin
                    state <= WRITE_WAIT;
                end
                WRITE_WAIT: begin
                    if (!mem_stall) begin
                        hit   <= hit_in;
                        valid <= 1'b1;
                        state <= DONE;
                    end
                end
                // Valid is high here, requests are not looked at
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == LOOKUP) begin
            fill_way_q <= victim_way;
            if (read_m && hit_in) begin
                data_out <= rd_word;
            end
        end
        // Requested word taken straight from the refill
        if (fill_en && (beat == addr[OFF_MSB:OFF_LSB])) begin
            data_out <= mem_rdata;
        end
    end

endmodule

// File: rtl/cache_store.sv
module cache_store
    import cache_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [WORD_SIZE-1:0] addr,
    input  logic                 lookup_en,
    input  logic                 fill_en,
    input  logic                 tag_write,
    input  logic                 write_hit_en,
    input  logic                 lru_touch,
    input  logic                 fill_way,
    input  logic [1:0]           fill_word,
    input  logic [WORD_SIZE-1:0] fill_data,
    input  logic [WORD_SIZE-1:0] data_in,
    output logic                 hit,
    output logic                 hit_way,
    output logic                 victim_way,
    output logic [WORD_SIZE-1:0] rd_word
);

    logic [TAG_W-1:0]    tag_q   [NUM_SETS][NUM_WAYS];
    logic [LINE_W-1:0]   line_q  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];

    // One bit per set holding the most recently used way
    logic [NUM_SETS-1:0] mru_q;

    logic                idx;
    logic [TAG_W-1:0]    tag;
    logic [1:0]          off;
    logic [NUM_WAYS-1:0] way_hit;

    assign idx = addr[IDX_BIT];
    assign tag = addr[TAG_MSB:TAG_LSB];
    assign off = addr[OFF_MSB:OFF_LSB];

    // Tag compare on both ways of the set
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = valid_q[idx][w] && (tag_q[idx][w] == tag);
        end
    end

    // Empty way first, else the one not used last
    always_comb begin
        if (!valid_q[idx][0]) begin
            victim_way = 1'b0;
        end else if (!valid_q[idx][1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = ~mru_q[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
            mru_q <= '0;
            hit   <= 1'b0;
        end else begin
            if (lookup_en) begin
                hit <= |way_hit;
            end
            // A completed refill also makes that way the newest
            if (tag_write) begin
                valid_q[idx][fill_way] <= 1'b1;
                mru_q[idx]             <= fill_way;
            end else if (lru_touch) begin
                mru_q[idx] <= fill_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            hit_way <= way_hit[1];
            rd_word <= line_q[idx][way_hit[1]][off*WORD_SIZE +: WORD_SIZE];
        end
        if (fill_en) begin
            line_q[idx][fill_way][fill_word*WORD_SIZE +: WORD_SIZE] <= fill_data;
        end
        if (tag_write) begin
            tag_q[idx][fill_way] <= tag;
        end
        // Keep the cached copy in step with the write-through
        if (write_hit_en) begin
            line_q[idx][fill_way][off*WORD_SIZE +: WORD_SIZE] <= data_in;
        end
    end

endmodule

// File: rtl/main_memory.sv
module main_memory
    import cache_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  logic [WORD_SIZE-1:0] mem_addr,
    input  logic [WORD_SIZE-1:0] mem_wdata,
    output logic [WORD_SIZE-1:0] mem_rdata,
    output logic                 mem_stall
);

    logic [WORD_SIZE-1:0] mem [MEM_WORDS];

    logic                 start;
    logic                 busy;
    logic                 done;
    logic [MEM_AW-1:0]    acc_addr;
    logic [WORD_SIZE-1:0] acc_wdata;
    logic                 acc_write;

    // New access only when the previous one has finished
    assign start = (mem_read || mem_write) && !busy;

    access_timer timer_inst (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .busy  (busy),
        .done  (done)
    );

    assign mem_stall = busy;

    // Request captured when the access begins
    always_ff @(posedge clk) begin
        if (start) begin
            acc_addr  <= mem_addr[MEM_AW:1];
            acc_wdata <= mem_wdata;
            acc_write <= mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= mem_init_word(i);
            end
        end else if (done && acc_write) begin
            mem[acc_addr] <= acc_wdata;
        end
    end

    // Read data shows up together with the stall release
    always_ff @(posedge clk) begin
        if (done && !acc_write) begin
            mem_rdata <= mem[acc_addr];
        end
    end

endmodule

// File: rtl/access_timer.sv
module access_timer
    import cache_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic busy,
    output logic done
);

    logic [MEM_LAT_W-1:0] count;

    // Loaded on start, runs down to zero while busy
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (start && !busy) begin
            count <= MEM_LAT_W'(MEM_LATENCY);
        end else if (busy) begin
            count <= count - 1'b1;
        end
    end

    assign busy = (count != '0);

    // Last busy cycle, busy falls at the next edge
    assign done = (count == MEM_LAT_W'(1));

endmodule

// File: rtl/cache_pkg.sv
package cache_pkg;

    // Machine word, also the address width
    localparam int WORD_SIZE = 16;

    // Address fields
    localparam int TAG_MSB = 15;
    localparam int TAG_LSB = 4;
    localparam int TAG_W   = TAG_MSB - TAG_LSB + 1;
    localparam int IDX_BIT = 3;
    localparam int OFF_MSB = 2;
    localparam int OFF_LSB = 1;

    // Cache organization
    localparam int NUM_SETS   = 2;
    localparam int NUM_WAYS   = 2;
    localparam int LINE_WORDS = 4;
    localparam int LINE_W     = LINE_WORDS * WORD_SIZE;

    // Backing memory, indexed by address bits 8 to 1
    localparam int MEM_WORDS   = 256;
    localparam int MEM_AW      = $clog2(MEM_WORDS);
    localparam int MEM_LATENCY = 4;
    localparam int MEM_LAT_W   = $clog2(MEM_LATENCY + 1);

    // Power-up content of memory word i
    function automatic logic [WORD_SIZE-1:0] mem_init_word(input int unsigned i);
        logic [WORD_SIZE-1:0] idx_w;
        idx_w = WORD_SIZE'(i);
        return (idx_w * 16'h0101) ^ 16'h5a3c;
    endfunction

endpackage
